/* stbuf_pkg.sv */
/*
 * store buffer shared definitions
 * address, line, word and strobe types, line data union, size constants
 */
`default_nettype none

package stbuf_pkg;

  // ------------------------------------------------
  // sizes
  // ------------------------------------------------
  localparam int ADDR_W     = 16;
  localparam int LINE_BYTES = 8;
  localparam int LINE_OFS_W = 3;
  localparam int WORD_BYTES = 4;
  localparam int LINE_WORDS = LINE_BYTES / WORD_BYTES;

  // ------------------------------------------------
  // basic types
  // ------------------------------------------------
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [ADDR_W-LINE_OFS_W-1:0] line_addr_t;
  typedef logic [8*WORD_BYTES-1:0]      word_t;
  typedef logic [WORD_BYTES-1:0]        strb_t;
  typedef logic [LINE_BYTES-1:0]        line_be_t;

  // one 64-bit line, seen as bytes or as words
  typedef union packed {
    logic [LINE_BYTES-1:0][7:0]               bytes;
    logic [LINE_WORDS-1:0][8*WORD_BYTES-1:0]  words;
  } line_data_u;

endpackage : stbuf_pkg

`default_nettype wire

/* stbuf_alloc.sv */
/*
 * commit side store receiver
 * four-phase handshake, merge search, allocation and input pointer
 */
`timescale 1ns/10ps
`default_nettype none

module stbuf_alloc #(
  parameter int ENTRIES = 4
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,
  input  wire logic                   i_st_req,
  input  wire stbuf_pkg::addr_t       i_st_addr,
  input  wire stbuf_pkg::word_t       i_st_data,
  input  wire stbuf_pkg::strb_t       i_st_strb,
  output logic                        o_st_ack,
  input  wire logic [ENTRIES-1:0]     i_valid,
  input  wire logic [ENTRIES-1:0]     i_draining,
  input  wire stbuf_pkg::line_addr_t  i_line_addr [ENTRIES],
  output logic [ENTRIES-1:0]          o_load,
  output logic [ENTRIES-1:0]          o_merge,
  output stbuf_pkg::line_addr_t       o_line_addr,
  output stbuf_pkg::line_data_u       o_line_word,
  output stbuf_pkg::line_be_t         o_line_be
);
  import stbuf_pkg::*;

  localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  logic [PTR_W-1:0]   r_in_ptr;
  logic [ENTRIES-1:0] w_hit;
  logic               w_pending;
  logic               w_can_alloc;
  logic               w_alloc;
  logic               w_take;

  // ------------------------------------------------
  // merge search and take decision
  // ------------------------------------------------
  assign o_line_addr = i_st_addr[ADDR_W-1:LINE_OFS_W];

  always_comb begin
    for (int e = 0; e < ENTRIES; e++) begin
      w_hit[e] = i_valid[e] & ~i_draining[e] & (i_line_addr[e] == o_line_addr);
    end
  end

  // request seen but not yet acked
  assign w_pending   = i_st_req & ~o_st_ack;
  assign w_can_alloc = ~i_valid[r_in_ptr];
  assign w_alloc     = w_pending & ~(|w_hit) & w_can_alloc;
  assign w_take      = w_pending & ((|w_hit) | w_can_alloc);

  always_comb begin
    for (int e = 0; e < ENTRIES; e++) begin
      o_merge[e] = w_pending & w_hit[e];
      o_load[e]  = w_alloc & (r_in_ptr == PTR_W'(e));
    end
  end

  // word placed into its half of the line
  always_comb begin
    o_line_word = '0;
    o_line_word.words[i_st_addr[LINE_OFS_W-1]] = i_st_data;
    o_line_be = i_st_addr[LINE_OFS_W-1] ? {i_st_strb, 4'b0000} : {4'b0000, i_st_strb};
  end

  // ------------------------------------------------
  // ack and input pointer
  // ------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_st_ack <= 1'b0;
      r_in_ptr <= '0;
    end else begin
      if (w_take) begin
        o_st_ack <= 1'b1;
      end else if (!i_st_req) begin
        o_st_ack <= 1'b0;
      end
      if (w_alloc) begin
        r_in_ptr <= (r_in_ptr == PTR_W'(ENTRIES-1)) ? '0 : r_in_ptr + 1'b1;
      end
    end
  end

endmodule : stbuf_alloc

`default_nettype wire

/* stbuf_entry.sv */
/*
 * single store buffer entry
 * line address, byte merge, draining state and free
 */
`timescale 1ns/10ps
`default_nettype none

module stbuf_entry (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,
  input  wire logic                   i_load,
  input  wire logic                   i_merge,
  input  wire stbuf_pkg::line_addr_t  i_line_addr,
  input  wire stbuf_pkg::line_data_u  i_line_word,
  input  wire stbuf_pkg::line_be_t    i_line_be,
  input  wire logic                   i_start_drain,
  input  wire logic                   i_free,
  output logic                        o_valid,
  output logic                        o_draining,
  output stbuf_pkg::line_addr_t       o_line_addr,
  output stbuf_pkg::line_data_u       o_data,
  output stbuf_pkg::line_be_t         o_be
);
  import stbuf_pkg::*;

  logic r_draining;

  // ------------------------------------------------
  // control state
  // ------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid    <= 1'b0;
      r_draining <= 1'b0;
    end else begin
      if (i_free) begin
        o_valid    <= 1'b0;
        r_draining <= 1'b0;
      end else begin
        if (i_load) begin
          o_valid <= 1'b1;
        end
        if (i_start_drain) begin
          r_draining <= 1'b1;
        end
      end
    end
  end

  // visible as draining already in the start cycle, so no merge slips in
  assign o_draining = r_draining | i_start_drain;

  // ------------------------------------------------
  // line payload
  // ------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_line_addr <= i_line_addr;
      o_data      <= i_line_word;
      o_be        <= i_line_be;
    end else if (i_merge) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (i_line_be[b]) begin
          o_data.bytes[b] <= i_line_word.bytes[b];
        end
      end
      o_be <= o_be | i_line_be;
    end
  end

endmodule : stbuf_entry

`default_nettype wire

/* stbuf_drain.sv */
/*
 * in-order drain controller
 * output pointer and four-phase memory write master
 */
`timescale 1ns/10ps
`default_nettype none

module stbuf_drain #(
  parameter int ENTRIES = 4
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,
  input  wire logic [ENTRIES-1:0]     i_valid,
  input  wire stbuf_pkg::line_addr_t  i_line_addr [ENTRIES],
  input  wire stbuf_pkg::line_data_u  i_data [ENTRIES],
  input  wire stbuf_pkg::line_be_t    i_be [ENTRIES],
  output logic [ENTRIES-1:0]          o_start_drain,
  output logic [ENTRIES-1:0]          o_free,
  output logic                        o_mem_req,
  output stbuf_pkg::line_addr_t       o_mem_addr,
  output stbuf_pkg::line_data_u       o_mem_data,
  output stbuf_pkg::line_be_t         o_mem_be,
  input  wire logic                   i_mem_ack
);
  import stbuf_pkg::*;

  localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_REQ      = 2'd1;
  localparam logic [1:0] ST_WAIT_LOW = 2'd2;

  logic [1:0]       r_state;
  logic [PTR_W-1:0] r_out_ptr;
  logic             w_start;
  logic             w_done;

  // ------------------------------------------------
  // handshake FSM
  // ------------------------------------------------
  assign w_start   = (r_state == ST_IDLE) & i_valid[r_out_ptr];
  // ack seen low again, write is complete
  assign w_done    = (r_state == ST_WAIT_LOW) & ~i_mem_ack;
  assign o_mem_req = (r_state == ST_REQ);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state   <= ST_IDLE;
      r_out_ptr <= '0;
    end else begin
      case (r_state)
        ST_IDLE: begin
          if (w_start) begin
            r_state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (i_mem_ack) begin
            r_state <= ST_WAIT_LOW;
          end
        end
        ST_WAIT_LOW: begin
          if (w_done) begin
            r_state   <= ST_IDLE;
            r_out_ptr <= (r_out_ptr == PTR_W'(ENTRIES-1)) ? '0 : r_out_ptr + 1'b1;
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    for (int e = 0; e < ENTRIES; e++) begin
      o_start_drain[e] = w_start & (r_out_ptr == PTR_W'(e));
      o_free[e]        = w_done & (r_out_ptr == PTR_W'(e));
    end
  end

  // ------------------------------------------------
  // memory payload, held until the next start
  // ------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (w_start) begin
      o_mem_addr <= i_line_addr[r_out_ptr];
      o_mem_data <= i_data[r_out_ptr];
      o_mem_be   <= i_be[r_out_ptr];
    end
  end

endmodule : stbuf_drain

`default_nettype wire

/* stbuf_fwd.sv */
/*
 * store-to-load forwarding selector
 * youngest matching entry, word and byte valids for one load
 */
`timescale 1ns/10ps
`default_nettype none

module stbuf_fwd #(
  parameter int ENTRIES = 4
) (
  input  wire stbuf_pkg::addr_t       i_ld_addr,
  input  wire logic [ENTRIES-1:0]     i_valid,
  input  wire logic [ENTRIES-1:0]     i_draining,
  input  wire stbuf_pkg::line_addr_t  i_line_addr [ENTRIES],
  input  wire stbuf_pkg::line_data_u  i_data [ENTRIES],
  input  wire stbuf_pkg::line_be_t    i_be [ENTRIES],
  output logic                        o_ld_fwd_valid,
  output stbuf_pkg::word_t            o_ld_fwd_data,
  output stbuf_pkg::strb_t            o_ld_fwd_strb
);
  import stbuf_pkg::*;

  logic [ENTRIES-1:0] w_match;
  logic [ENTRIES-1:0] w_young;
  logic [ENTRIES-1:0] w_sel;
  line_data_u         w_data;
  line_be_t           w_be;
  logic               w_upper;

  always_comb begin
    for (int e = 0; e < ENTRIES; e++) begin
      w_match[e] = i_valid[e] & (i_line_addr[e] == i_ld_addr[ADDR_W-1:LINE_OFS_W]);
    end
  end

  // non-draining entry is the younger one
  assign w_young = w_match & ~i_draining;
  assign w_sel   = (|w_young) ? w_young : w_match;

  // one-hot OR select
  always_comb begin
    w_data = '0;
    w_be   = '0;
    for (int e = 0; e < ENTRIES; e++) begin
      if (w_sel[e]) begin
        w_data = w_data | i_data[e];
        w_be   = w_be | i_be[e];
      end
    end
  end

  assign w_upper        = i_ld_addr[LINE_OFS_W-1];
  assign o_ld_fwd_data  = w_data.words[w_upper];
  assign o_ld_fwd_strb  = w_upper ? w_be[7:4] : w_be[3:0];
  assign o_ld_fwd_valid = |o_ld_fwd_strb;

endmodule : stbuf_fwd

`default_nettype wire

/* stbuf_top.sv */
/*
 * store buffer top level
 * allocator, entry array, drain controller and forwarding selector
 */
`timescale 1ns/10ps
`default_nettype none

module stbuf_top #(
  parameter int ENTRIES = 4
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset_n,
  input  wire logic                   i_st_req,
  input  wire stbuf_pkg::addr_t       i_st_addr,
  input  wire stbuf_pkg::word_t       i_st_data,
  input  wire stbuf_pkg::strb_t       i_st_strb,
  output logic                        o_st_ack,
  output logic                        o_mem_req,
  output stbuf_pkg::line_addr_t       o_mem_addr,
  output stbuf_pkg::line_data_u       o_mem_data,
  output stbuf_pkg::line_be_t         o_mem_be,
  input  wire logic                   i_mem_ack,
  input  wire stbuf_pkg::addr_t       i_ld_addr,
  output logic                        o_ld_fwd_valid,
  output stbuf_pkg::word_t            o_ld_fwd_data,
  output stbuf_pkg::strb_t            o_ld_fwd_strb
);
  import stbuf_pkg::*;

  logic [ENTRIES-1:0] w_load;
  logic [ENTRIES-1:0] w_merge;
  logic [ENTRIES-1:0] w_start_drain;
  logic [ENTRIES-1:0] w_free;
  logic [ENTRIES-1:0] w_valid;
  logic [ENTRIES-1:0] w_draining;
  line_addr_t         w_in_line_addr;
  line_data_u         w_in_line_word;
  line_be_t           w_in_line_be;
  line_addr_t         w_ent_line_addr [ENTRIES];
  line_data_u         w_ent_data [ENTRIES];
  line_be_t           w_ent_be [ENTRIES];

  stbuf_alloc #(.ENTRIES(ENTRIES)) u_alloc (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_st_req    (i_st_req),
    .i_st_addr   (i_st_addr),
    .i_st_data   (i_st_data),
    .i_st_strb   (i_st_strb),
    .o_st_ack    (o_st_ack),
    .i_valid     (w_valid),
    .i_draining  (w_draining),
    .i_line_addr (w_ent_line_addr),
    .o_load      (w_load),
    .o_merge     (w_merge),
    .o_line_addr (w_in_line_addr),
    .o_line_word (w_in_line_word),
    .o_line_be   (w_in_line_be)
  );

  // ------------------------------------------------
  // entry array
  // ------------------------------------------------
  for (genvar e = 0; e < ENTRIES; e++) begin : g_entry
    stbuf_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_load        (w_load[e]),
      .i_merge       (w_merge[e]),
      .i_line_addr   (w_in_line_addr),
      .i_line_word   (w_in_line_word),
      .i_line_be     (w_in_line_be),
      .i_start_drain (w_start_drain[e]),
      .i_free        (w_free[e]),
      .o_valid       (w_valid[e]),
      .o_draining    (w_draining[e]),
      .o_line_addr   (w_ent_line_addr[e]),
      .o_data        (w_ent_data[e]),
      .o_be          (w_ent_be[e])
    );
  end

  stbuf_drain #(.ENTRIES(ENTRIES)) u_drain (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_valid       (w_valid),
    .i_line_addr   (w_ent_line_addr),
    .i_data        (w_ent_data),
    .i_be          (w_ent_be),
    .o_start_drain (w_start_drain),
    .o_free        (w_free),
    .o_mem_req     (o_mem_req),
    .o_mem_addr    (o_mem_addr),
    .o_mem_data    (o_mem_data),
    .o_mem_be      (o_mem_be),
    .i_mem_ack     (i_mem_ack)
  );

  stbuf_fwd #(.ENTRIES(ENTRIES)) u_fwd (
    .i_ld_addr      (i_ld_addr),
    .i_valid        (w_valid),
    .i_draining     (w_draining),
    .i_line_addr    (w_ent_line_addr),
    .i_data         (w_ent_data),
    .i_be           (w_ent_be),
    .o_ld_fwd_valid (o_ld_fwd_valid),
    .o_ld_fwd_data  (o_ld_fwd_data),
    .o_ld_fwd_strb  (o_ld_fwd_strb)
  );

endmodule : stbuf_top

`default_nettype wire

/* stbuf_chk.sv */
/*
 * protocol checker bound to the store buffer top
 * commit and memory handshake assertions
 */
`timescale 1ns/10ps
`default_nettype none

module stbuf_chk (
  input wire logic                   i_clk,
  input wire logic                   i_reset_n,
  input wire logic                   i_st_req,
  input wire logic                   i_st_ack,
  input wire logic                   i_mem_req,
  input wire stbuf_pkg::line_addr_t  i_mem_addr,
  input wire stbuf_pkg::line_data_u  i_mem_data,
  input wire stbuf_pkg::line_be_t    i_mem_be,
  input wire logic                   i_mem_ack
);

  int fail_count = 0;

  // ack only answers a live request
  a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $rose(i_st_ack) |-> i_st_req)
    else begin
      $error("o_st_ack rose while i_st_req was low");
      fail_count++;
    end

  // write payload held through the whole memory handshake
  a_mem_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $past(i_mem_req || i_mem_ack) |-> $stable({i_mem_addr, i_mem_data, i_mem_be}))
    else begin
      $error("memory payload changed during a write");
      fail_count++;
    end

  a_mem_be: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req |-> (i_mem_be != '0))
    else begin
      $error("memory write with empty byte enables");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> (!i_st_ack && !i_mem_req))
    else begin
      $error("handshake outputs active during reset");
      fail_count++;
    end

endmodule : stbuf_chk

`default_nettype wire

/* tb_stbuf.sv */
/*
 * testbench for the store buffer
 * commit driver, memory responder, reference model and checks
 */
`timescale 1ns/10ps
`default_nettype none

module tb_stbuf;
  import stbuf_pkg::*;

  localparam int N_RANDOM = 200;
  localparam int N_STORES = N_RANDOM + 3 + 5;
  localparam int LIMIT    = 40 * N_STORES + 2000;
  localparam int N_LINES  = 1 << (ADDR_W - LINE_OFS_W);

  logic       clk;
  logic       reset_n;
  logic       st_req;
  addr_t      st_addr;
  word_t      st_data;
  strb_t      st_strb;
  logic       st_ack;
  logic       mem_req;
  line_addr_t mem_addr;
  line_data_u mem_data;
  line_be_t   mem_be;
  logic       mem_ack;
  addr_t      ld_addr;
  logic       fwd_valid;
  word_t      fwd_data;
  strb_t      fwd_strb;

  logic       stall;
  int         stim_seed;
  int         resp_seed;
  int         delay_cnt;
  int         cycles;
  int         n_groups;
  int         n_wr;
  logic       prev_st_ack;
  logic       prev_mem_req;

  line_data_u mem [N_LINES];
  line_data_u ref_img [N_LINES];
  line_data_u open_data [N_LINES];
  line_be_t   open_be [N_LINES];
  logic       open_valid [N_LINES];
  int         wr_count [N_LINES];

  stbuf_top #(.ENTRIES(4)) i_dut (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_st_req       (st_req),
    .i_st_addr      (st_addr),
    .i_st_data      (st_data),
    .i_st_strb      (st_strb),
    .o_st_ack       (st_ack),
    .o_mem_req      (mem_req),
    .o_mem_addr     (mem_addr),
    .o_mem_data     (mem_data),
    .o_mem_be       (mem_be),
    .i_mem_ack      (mem_ack),
    .i_ld_addr      (ld_addr),
    .o_ld_fwd_valid (fwd_valid),
    .o_ld_fwd_data  (fwd_data),
    .o_ld_fwd_strb  (fwd_strb)
  );

  bind stbuf_top stbuf_chk u_chk (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_st_req   (i_st_req),
    .i_st_ack   (o_st_ack),
    .i_mem_req  (o_mem_req),
    .i_mem_addr (o_mem_addr),
    .i_mem_data (o_mem_data),
    .i_mem_be   (o_mem_be),
    .i_mem_ack  (i_mem_ack)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic line_data_u fill_line(int l);
    line_data_u r;
    r.words[0] = {3'b000, l[12:0], 3'b101, ~l[12:0]};
    r.words[1] = 32'h9e37_0000 ^ {l[12:0], 19'h0} ^ {19'h0, l[12:0]};
    return r;
  endfunction

  // byte-wise write of one store into a line image
  function automatic line_data_u apply_store(line_data_u img, addr_t a, word_t d, strb_t s);
    line_data_u r;
    r = img;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        r.bytes[4 * int'(a[2]) + b] = d[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic line_be_t store_be(addr_t a, strb_t s);
    line_be_t be;
    be = '0;
    for (int b = 0; b < 4; b++) begin
      be[4 * int'(a[2]) + b] = s[b];
    end
    return be;
  endfunction

  function automatic line_data_u mask_line(line_data_u d, line_be_t be);
    line_data_u r;
    r = '0;
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (be[b]) begin
        r.bytes[b] = d.bytes[b];
      end
    end
    return r;
  endfunction

  function automatic word_t mask_word(word_t w, strb_t s);
    word_t r;
    r = '0;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        r[8*b +: 8] = w[8*b +: 8];
      end
    end
    return r;
  endfunction

  // --------------------------------------------------
  // error reporting and compares
  // --------------------------------------------------
  task automatic fail_run(string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_line(string name, line_data_u got, line_data_u exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_strb(string name, strb_t got, strb_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_be(string name, line_be_t got, line_be_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_image();
    for (int l = 0; l < N_LINES; l++) begin
      check_line($sformatf("mem[%0h]", l), mem[l], ref_img[l]);
    end
  endtask

  // --------------------------------------------------
  // memory responder
  // --------------------------------------------------
  always @(posedge clk) begin
    if (mem_req && !mem_ack) begin
      if (delay_cnt != 0) begin
        delay_cnt <= delay_cnt - 1;
      end else if (!stall) begin
        mem_ack <= 1'b1;
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (mem_be[b]) begin
            mem[mem_addr].bytes[b] <= mem_data.bytes[b];
          end
        end
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack   <= 1'b0;
      delay_cnt <= int'($unsigned($random(resp_seed)) % 6);
    end
  end

  // --------------------------------------------------
  // compare process, sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk) begin
    line_addr_t ln;
    strb_t      exp_strb;
    cycles++;
    if (cycles > LIMIT) begin
      fail_run($sformatf("timeout: run did not finish within %0d cycles", LIMIT));
    end
    if (i_dut.u_chk.fail_count != 0) begin
      fail_run("protocol assertion failed in the bound checker");
    end
    if (reset_n) begin
      // write start closes the open group of its line
      if (mem_req && !prev_mem_req) begin
        if (!open_valid[mem_addr]) begin
          fail_run($sformatf("memory write to line %h with no pending store", mem_addr));
        end
        check_be("o_mem_be", mem_be, open_be[mem_addr]);
        check_line("o_mem_data", mask_line(mem_data, mem_be),
                   mask_line(open_data[mem_addr], open_be[mem_addr]));
        open_valid[mem_addr] = 1'b0;
        wr_count[mem_addr]++;
        n_wr++;
      end
      // store taken, then lookup of its own word
      if (st_ack && !prev_st_ack) begin
        ln = st_addr[ADDR_W-1:LINE_OFS_W];
        ref_img[ln] = apply_store(ref_img[ln], st_addr, st_data, st_strb);
        if (!open_valid[ln]) begin
          open_valid[ln] = 1'b1;
          open_data[ln]  = '0;
          open_be[ln]    = '0;
          n_groups++;
        end
        open_data[ln] = apply_store(open_data[ln], st_addr, st_data, st_strb);
        open_be[ln]   = open_be[ln] | store_be(st_addr, st_strb);
        exp_strb = st_addr[2] ? open_be[ln][7:4] : open_be[ln][3:0];
        check_flag("o_ld_fwd_valid", fwd_valid, |exp_strb);
        check_strb("o_ld_fwd_strb", fwd_strb, exp_strb);
        check_word("o_ld_fwd_data", mask_word(fwd_data, exp_strb),
                   mask_word(open_data[ln].words[st_addr[2]], exp_strb));
      end
    end
    prev_st_ack  = st_ack;
    prev_mem_req = mem_req;
  end

  // --------------------------------------------------
  // commit side driver
  // --------------------------------------------------
  task automatic store_begin(addr_t a, word_t d, strb_t s);
    @(posedge clk);
    st_req  <= 1'b1;
    st_addr <= a;
    st_data <= d;
    st_strb <= s;
    ld_addr <= a;
  endtask

  task automatic store_end();
    do @(negedge clk); while (!st_ack);
    @(posedge clk);
    st_req <= 1'b0;
    do @(negedge clk); while (st_ack);
  endtask

  task automatic store(addr_t a, word_t d, strb_t s);
    store_begin(a, d, s);
    store_end();
  endtask

  task automatic wait_idle();
    do @(posedge clk); while (n_wr != n_groups || mem_req || mem_ack);
    repeat (3) @(posedge clk);
  endtask

  initial begin
    logic [31:0] r;
    addr_t       a;
    strb_t       s;
    int          wr_before;
    clk       = 1'b0;
    reset_n   = 1'b0;
    st_req    = 1'b0;
    st_addr   = '0;
    st_data   = '0;
    st_strb   = '0;
    mem_ack   = 1'b0;
    ld_addr   = '0;
    stall     = 1'b0;
    stim_seed = 32'hca28_b828;
    resp_seed = 32'hca28_b828;
    delay_cnt = 0;
    cycles    = 0;
    n_groups  = 0;
    n_wr      = 0;
    prev_st_ack  = 1'b0;
    prev_mem_req = 1'b0;
    for (int l = 0; l < N_LINES; l++) begin
      mem[l]        = fill_line(l);
      ref_img[l]    = fill_line(l);
      open_valid[l] = 1'b0;
      wr_count[l]   = 0;
    end

    // reset, outputs quiet through the first free cycle
    repeat (16) begin
      @(negedge clk);
      check_flag("o_st_ack", st_ack, 1'b0);
      check_flag("o_mem_req", mem_req, 1'b0);
    end
    @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_flag("o_st_ack", st_ack, 1'b0);
    check_flag("o_mem_req", mem_req, 1'b0);

    // random stores over four lines
    for (int n = 0; n < N_RANDOM; n++) begin
      r = $random(stim_seed);
      a = r[15:0] & 16'h001c;
      r = $random(stim_seed);
      s = r[3:0];
      if (s == '0) begin
        s = 4'b1001;
      end
      store(a, $random(stim_seed), s);
    end
    wait_idle();
    compare_image();

    // merge behind a stalled write
    @(posedge clk);
    stall <= 1'b1;
    wr_before = wr_count[9];
    store(16'h0040, 32'h1111_2222, 4'b1111);
    store(16'h0048, 32'haaaa_bbbb, 4'b0011);
    store(16'h0048, 32'hcccc_dddd, 4'b0110);
    @(posedge clk);
    stall <= 1'b0;
    wait_idle();
    if (wr_count[9] != wr_before + 1) begin
      fail_run($sformatf("merged line was written %0d times instead of once",
                         wr_count[9] - wr_before));
    end

    // full buffer holds the fifth store off
    @(posedge clk);
    stall <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      store(16'h0080 + 16'(8 * k), 32'h5000_0000 + k, 4'b1111);
    end
    store_begin(16'h00a4, 32'h5000_00ff, 4'b1100);
    @(posedge clk);
    ld_addr <= 16'h8000;
    repeat (50) begin
      @(negedge clk);
      if (st_ack) begin
        fail_run("store was acked while all entries were in use");
      end
      check_flag("o_ld_fwd_valid", fwd_valid, 1'b0);
    end
    @(posedge clk);
    ld_addr <= 16'h00a4;
    stall   <= 1'b0;
    store_end();
    wait_idle();
    compare_image();

    if (i_dut.u_chk.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      fail_run("protocol assertion failed in the bound checker");
    end
  end

endmodule : tb_stbuf

`default_nettype wire

/* stbuf.f */
stbuf_pkg.sv
stbuf_alloc.sv
stbuf_entry.sv
stbuf_drain.sv
stbuf_fwd.sv
stbuf_top.sv
stbuf_chk.sv
tb_stbuf.sv
